/* Makefile */
# Verilator build and run for the byte-addressable co-processor testbench

VERILATOR  ?= verilator
TOP        := tb_rop_ba_cop
FILELIST   := rop_ba_cop.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
PASS_MSG   := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Pass only when the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rop_arith_unit.sv */
/*
 * Padded byte logic unit. Operand low bytes come from the registers, the upper
 * 24 bits from the PRNG. Result is ready in the request cycle.
 */
`timescale 1ns/10ps

module rop_arith_unit (
    input  rop_isa_pkg::dec_instr_t dec,
    input  rop_bus_pkg::word_t      rs1,
    input  rop_bus_pkg::word_t      rs2,
    input  rop_bus_pkg::rand_t      rnd,
    output rop_bus_pkg::unit_res_t  res
);

    rop_bus_pkg::word_t lhs;
    rop_bus_pkg::word_t rhs;
    rop_bus_pkg::word_t result;

    // ------------------------------
    // Operand padding
    // ------------------------------
    assign lhs = {rnd[31:8],  rs1[7:0]}; // Separate PRNG slices
    assign rhs = {rnd[55:32], rs2[7:0]}; // so the pads differ

    // Whole word is computed, pad bits mask the real byte's neighbours
    always_comb begin
        case (dec.logic_op)
            rop_isa_pkg::LOP_XOR: result = lhs ^ rhs;
            rop_isa_pkg::LOP_AND: result = lhs & rhs;
            rop_isa_pkg::LOP_OR:  result = lhs | rhs;
            default:              result = '0;
        endcase
    end

    // ------------------------------
    // Report to writeback
    // ------------------------------
    always_comb begin
        res.valid = (dec.logic_op != rop_isa_pkg::LOP_NONE);
        res.done  = res.valid; // Zero latency
        res.data  = result;
    end

endmodule

/* rop_ba_cop.f */
rop_bus_pkg.sv
rop_isa_pkg.sv
rop_prng.sv
rop_decode.sv
rop_arith_unit.sv
rop_mem_unit.sv
rop_writeback.sv
rop_ba_cop.sv
tb_rop_ba_cop.sv

/* rop_ba_cop.sv */
/*
 * Random operand padded, byte addressable co-processor top level. The cop_*
 * inputs must stay stable from cop_req until cop_rsp.
 */
`timescale 1ns/10ps

module rop_ba_cop #(
    parameter rop_bus_pkg::rand_t PRNG_SEED = 64'h5A3C_96E1_0F7B_24D8
) (
    input  logic                  clk,
    output logic                  clk_req,          // Clock wanted while busy
    input  logic                  rst_n,

    input  logic                  cop_req,
    output logic                  cop_acc,
    output logic                  cop_rsp,
    input  rop_bus_pkg::word_t    cop_instr_in,
    input  rop_bus_pkg::word_t    cop_rs1,
    input  rop_bus_pkg::word_t    cop_rs2,

    output logic [2:0]            cop_rd_byte,      // Byte index or whole word
    output rop_bus_pkg::reg_idx_t cop_rd,
    output rop_bus_pkg::word_t    cop_wdata,
    output logic                  cop_wen,

    output logic                  cop_mem_ld_error,
    output logic                  cop_mem_st_error,

    output logic                  cop_mem_cen,
    input  logic                  cop_mem_stall,
    input  logic                  cop_mem_error,
    output logic                  cop_mem_wen,
    output rop_bus_pkg::ben_t     cop_mem_ben,
    output rop_bus_pkg::word_t    cop_mem_wdata,
    input  rop_bus_pkg::word_t    cop_mem_rdata,
    output rop_bus_pkg::addr_t    cop_mem_addr
);

    rop_isa_pkg::dec_instr_t dec;
    rop_bus_pkg::rand_t      prng_out;
    rop_bus_pkg::unit_res_t  arith_res;
    rop_bus_pkg::unit_res_t  mem_res;
    rop_bus_pkg::mem_req_t   mem_req;
    rop_bus_pkg::mem_rsp_t   mem_rsp;

    assign clk_req = cop_req; // No gating logic of our own

    // ------------------------------
    // Memory pin packing
    // ------------------------------
    assign mem_rsp       = '{stall: cop_mem_stall, error: cop_mem_error, rdata: cop_mem_rdata};
    assign cop_mem_cen   = mem_req.cen;
    assign cop_mem_wen   = mem_req.wen;
    assign cop_mem_ben   = mem_req.ben;
    assign cop_mem_addr  = mem_req.addr;
    assign cop_mem_wdata = mem_req.wdata;

    // ------------------------------
    // Decode and padding source
    // ------------------------------
    rop_decode u_decode (
        .cop_req (cop_req),
        .instr   (cop_instr_in),
        .dec     (dec),
        .cop_acc (cop_acc)
    );

    rop_prng #(
        .PRNG_SEED (PRNG_SEED)
    ) u_prng (
        .clk        (clk),
        .rst_n      (rst_n),
        .rng_random (prng_out)
    );

    // ------------------------------
    // Execution units, in parallel
    // ------------------------------
    rop_arith_unit u_arith (
        .dec (dec),
        .rs1 (cop_rs1),
        .rs2 (cop_rs2),
        .rnd (prng_out),
        .res (arith_res)
    );

    rop_mem_unit u_mem (
        .dec      (dec),
        .rs1      (cop_rs1),
        .rs2      (cop_rs2),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .res      (mem_res),
        .ld_error (cop_mem_ld_error),
        .st_error (cop_mem_st_error)
    );

    // Result merge and register write
    rop_writeback u_wb (
        .dec         (dec),
        .arith_res   (arith_res),
        .mem_res     (mem_res),
        .cop_rsp     (cop_rsp),
        .cop_wen     (cop_wen),
        .cop_wdata   (cop_wdata),
        .cop_rd      (cop_rd),
        .cop_rd_byte (cop_rd_byte)
    );

endmodule

/* rop_bus_pkg.sv */
/*
 * Bus-level types shared by the co-processor datapath and its memory port.
 * Unit results and memory request/response bundles travel as packed structs.
 */
package rop_bus_pkg;

    // ------------------------------
    // Plain vector types
    // ------------------------------
    typedef logic [31:0] word_t;    // Register / data word
    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [4:0]  reg_idx_t; // GPR index
    typedef logic [63:0] rand_t;    // PRNG output
    typedef logic [3:0]  ben_t;     // Byte lane enables

    // ------------------------------
    // Memory port bundles
    // ------------------------------

    // Driven by the memory unit, flattened at the top level
    typedef struct packed {
        logic  cen;   // Transfer pending while high
        logic  wen;   // Store
        ben_t  ben;   // One-hot byte lane
        addr_t addr;  // Word aligned
        word_t wdata; // Store data, unshifted
    } mem_req_t;

    // Comes back from the memory
    typedef struct packed {
        logic  stall; // Hold, nothing completes
        logic  error; // Ends the transfer
        word_t rdata;
    } mem_rsp_t;

    // Each execution unit reports to writeback with this
    typedef struct packed {
        logic  valid; // Unit owns the current instruction
        logic  done;  // Result ready this cycle
        word_t data;
    } unit_res_t;

endpackage

/* rop_decode.sv */
/*
 * Instruction decoder. Fully combinational, gated by cop_req so that an idle
 * interface decodes to no operation and no accept.
 */
`timescale 1ns/10ps

module rop_decode (
    input  logic                    cop_req,
    input  rop_bus_pkg::word_t      instr,
    output rop_isa_pkg::dec_instr_t dec,
    output logic                    cop_acc
);

    rop_isa_pkg::opcode_t opcode;
    rop_isa_pkg::funct3_t f3;
    rop_isa_pkg::funct7_t f7;
    rop_bus_pkg::word_t   s_imm;
    rop_bus_pkg::word_t   i_imm;
    logic                 in_ise;

    // ------------------------------
    // Field extraction
    // ------------------------------
    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign f7     = instr[31:25];

    assign s_imm  = {{20{instr[31]}}, instr[31:25], instr[11:7]}; // Store form
    assign i_imm  = {{20{instr[31]}}, instr[31:20]};              // Load form

    assign in_ise = cop_req && (opcode == rop_isa_pkg::ISE_OPCODE);

    // ------------------------------
    // Operation decode
    // ------------------------------
    always_comb begin
        dec        = '0;
        dec.rd     = instr[11:7];
        dec.offset = i_imm;
        if (in_ise) begin
            case (f3)
                rop_isa_pkg::F3_SB_B: begin
                    dec.mem_op   = rop_isa_pkg::MEM_STORE;
                    dec.is_store = 1'b1;
                    dec.offset   = s_imm; // Split immediate
                end
                rop_isa_pkg::F3_LB_B: begin
                    dec.mem_op    = rop_isa_pkg::MEM_LOAD;
                end
                rop_isa_pkg::F3_LB_BK: begin
                    dec.mem_op    = rop_isa_pkg::MEM_LOAD;
                    dec.rand_keep = 1'b1;
                end
                rop_isa_pkg::F3_R: begin
                    case (f7)
                        rop_isa_pkg::F7_XOR_RB:  dec.logic_op = rop_isa_pkg::LOP_XOR;
                        rop_isa_pkg::F7_AND_RB:  dec.logic_op = rop_isa_pkg::LOP_AND;
                        rop_isa_pkg::F7_OR_RB:   dec.logic_op = rop_isa_pkg::LOP_OR;
                        rop_isa_pkg::F7_XOR_RBK: begin
                            dec.logic_op  = rop_isa_pkg::LOP_XOR;
                            dec.rand_keep = 1'b1;
                        end
                        rop_isa_pkg::F7_AND_RBK: begin
                            dec.logic_op  = rop_isa_pkg::LOP_AND;
                            dec.rand_keep = 1'b1;
                        end
                        rop_isa_pkg::F7_OR_RBK: begin
                            dec.logic_op  = rop_isa_pkg::LOP_OR;
                            dec.rand_keep = 1'b1;
                        end
                        default: ; // Unknown f7, stays NONE
                    endcase
                end
                default: ; // Unused f3 slots
            endcase
        end
        // Anything that selected a unit counts as accepted
        dec.accept = (dec.logic_op != rop_isa_pkg::LOP_NONE) ||
                     (dec.mem_op   != rop_isa_pkg::MEM_NONE);
    end

    assign cop_acc = dec.accept;

endmodule

/* rop_isa_pkg.sv */
/*
 * Encodings of the custom byte-addressable instruction set and the decoded form
 * handed from the decoder to the execution units and writeback.
 */
package rop_isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [2:0] wb_mode_t; // Destination byte / whole-word select

    // Custom-1 major opcode
    localparam opcode_t ISE_OPCODE = 7'b0101011;

    // ------------------------------
    // funct3 space
    // ------------------------------
    localparam funct3_t F3_SB_B  = 3'b000;
    localparam funct3_t F3_R     = 3'b001; // Logic ops, f7 selects
    localparam funct3_t F3_LB_B  = 3'b010;
    localparam funct3_t F3_LB_BK = 3'b011;

    // funct7 for R-type, bit 0 marks the K form
    localparam funct7_t F7_XOR_RB  = 7'b0000000;
    localparam funct7_t F7_XOR_RBK = 7'b0000001;
    localparam funct7_t F7_AND_RB  = 7'b0000010;
    localparam funct7_t F7_AND_RBK = 7'b0000011;
    localparam funct7_t F7_OR_RB   = 7'b0000100;
    localparam funct7_t F7_OR_RBK  = 7'b0000101;

    // Whole-word writeback, as opposed to {0, byte index}
    localparam wb_mode_t WB_WORD = 3'b100;

    typedef enum logic [1:0] {
        LOP_NONE,
        LOP_XOR,
        LOP_AND,
        LOP_OR
    } logic_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    // Decoder output, one per offered instruction
    typedef struct packed {
        logic                 accept;    // One of the nine encodings
        logic_op_e            logic_op;
        mem_op_e              mem_op;
        logic                 rand_keep; // K forms, whole word written back
        logic                 is_store;
        rop_bus_pkg::reg_idx_t rd;
        rop_bus_pkg::word_t    offset;   // Sign-extended S or I immediate
    } dec_instr_t;

endpackage

/* rop_mem_unit.sv */
/*
 * Byte load/store unit. Forms the address, drives the chip-enable memory port
 * and flags completion once the memory stops stalling or reports an error.
 */
`timescale 1ns/10ps

module rop_mem_unit (
    input  rop_isa_pkg::dec_instr_t dec,
    input  rop_bus_pkg::word_t      rs1,
    input  rop_bus_pkg::word_t      rs2,
    output rop_bus_pkg::mem_req_t   mem_req,
    input  rop_bus_pkg::mem_rsp_t   mem_rsp,
    output rop_bus_pkg::unit_res_t  res,
    output logic                    ld_error,
    output logic                    st_error
);

    rop_bus_pkg::addr_t byte_addr;
    logic               mem_op;
    logic               done;

    assign byte_addr = rs1 + rop_bus_pkg::addr_t'(dec.offset); // Wraps, no carry out
    assign mem_op    = (dec.mem_op != rop_isa_pkg::MEM_NONE);

    // ------------------------------
    // Port drive
    // ------------------------------
    always_comb begin
        mem_req.cen   = mem_op;                   // Only for a real memory op
        mem_req.wen   = mem_op && dec.is_store;
        mem_req.ben   = rop_bus_pkg::ben_t'(4'b0001 << byte_addr[1:0]);
        mem_req.addr  = {byte_addr[31:2], 2'b00}; // Word aligned
        mem_req.wdata = rs2;
    end

    // First non-stalled cycle, or an error, ends the transfer
    assign done = mem_req.cen && (!mem_rsp.stall || mem_rsp.error);

    // ------------------------------
    // Completion and errors
    // ------------------------------
    always_comb begin
        res.valid = mem_op;
        res.done  = done;
        res.data  = mem_rsp.rdata;
    end

    assign ld_error = mem_req.cen && mem_rsp.error && !dec.is_store;
    assign st_error = mem_req.cen && mem_rsp.error &&  dec.is_store;

endmodule

/* rop_prng.sv */
/*
 * Free-running 64-bit Fibonacci LFSR supplying padding bits to the logic unit.
 * Loads the seed under reset, then steps on every clock.
 */
`timescale 1ns/10ps

module rop_prng #(
    parameter rop_bus_pkg::rand_t PRNG_SEED = 64'h5A3C_96E1_0F7B_24D8 // Must be non-zero
) (
    input  logic               clk,
    input  logic               rst_n,
    output rop_bus_pkg::rand_t rng_random
);

    rop_bus_pkg::rand_t lfsr_q;
    logic               feedback;

    // Taps 64, 63, 61, 60, maximal length
    assign feedback = lfsr_q[63] ^ lfsr_q[62] ^ lfsr_q[60] ^ lfsr_q[59];

    // ------------------------------
    // State
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr_q <= PRNG_SEED;                  // Seed load
        end else begin
            lfsr_q <= {lfsr_q[62:0], feedback};   // Shift in at the bottom
        end
    end

    assign rng_random = lfsr_q; // Whole register, consumer picks slices

endmodule

/* rop_writeback.sv */
/*
 * Merges the two unit results into the co-processor response and the register
 * write, including the byte / argument-register destination mapping.
 */
`timescale 1ns/10ps

module rop_writeback (
    input  rop_isa_pkg::dec_instr_t dec,
    input  rop_bus_pkg::unit_res_t  arith_res,
    input  rop_bus_pkg::unit_res_t  mem_res,
    output logic                    cop_rsp,
    output logic                    cop_wen,
    output rop_bus_pkg::word_t      cop_wdata,
    output rop_bus_pkg::reg_idx_t   cop_rd,
    output logic [2:0]              cop_rd_byte
);

    localparam rop_bus_pkg::reg_idx_t AREG_BASE = 5'd10; // a0 in the ABI

    rop_bus_pkg::reg_idx_t areg_rd;
    logic                  load_done;

    // ------------------------------
    // Response and write enable
    // ------------------------------
    assign load_done = mem_res.done && (dec.mem_op == rop_isa_pkg::MEM_LOAD);

    assign cop_rsp   = arith_res.done || mem_res.done;
    assign cop_wen   = (arith_res.valid && arith_res.done) || load_done; // Stores never write

    // Memory data wins whenever the memory unit owns the instruction
    assign cop_wdata = mem_res.valid ? mem_res.data : arith_res.data;

    // ------------------------------
    // Destination mapping
    // ------------------------------

    // K forms land on a0..a7
    assign areg_rd = AREG_BASE + rop_bus_pkg::reg_idx_t'(dec.rd[2:0]);

    always_comb begin
        if (dec.rand_keep) begin
            cop_rd      = areg_rd;
            cop_rd_byte = rop_isa_pkg::WB_WORD;   // Pad bits kept, whole word
        end else begin
            cop_rd      = dec.rd;
            cop_rd_byte = {1'b0, dec.rd[4:3]};    // Byte index from top of rd
        end
    end

endmodule

/* tb_rop_ba_cop.sv */
/*
 * Table-driven testbench for the byte-addressable co-processor. Fills a case
 * table from an LFSR, applies it row by row and models a stalling memory.
 */
`timescale 1ns/10ps

module tb_rop_ba_cop;

    localparam int         TIMEOUT = 40;          // Cycles per response wait
    localparam logic [6:0] ISE_OP  = 7'b0101011;  // Custom opcode

    typedef struct packed {
        rop_bus_pkg::word_t instr;
        rop_bus_pkg::word_t rs1;
        rop_bus_pkg::word_t rs2;
        logic [2:0]         stall;       // Stall cycles before completion
        logic               err;         // Inject a memory error
        rop_bus_pkg::word_t rdata;
        logic               exp_acc;
        logic               is_mem;
        logic               exp_wen;
        logic [4:0]         exp_rd;
        logic [2:0]         exp_rd_byte;
        logic [7:0]         exp_byte;    // Low byte of a logic result
        rop_bus_pkg::addr_t exp_addr;
        logic [3:0]         exp_ben;
        logic               exp_mem_wen;
        logic [1:0]         exp_err;     // 0 none, 1 load, 2 store
    } test_row_t;

    logic clk;
    logic clk_req;
    logic rst_n;
    logic cop_req;
    logic cop_acc;
    logic cop_rsp;
    logic cop_wen;
    logic cop_mem_ld_error;
    logic cop_mem_st_error;
    logic cop_mem_cen;
    logic cop_mem_stall;
    logic cop_mem_error;
    logic cop_mem_wen;
    logic [2:0]            cop_rd_byte;
    rop_bus_pkg::reg_idx_t cop_rd;
    rop_bus_pkg::word_t    cop_instr_in;
    rop_bus_pkg::word_t    cop_rs1;
    rop_bus_pkg::word_t    cop_rs2;
    rop_bus_pkg::word_t    cop_wdata;
    rop_bus_pkg::ben_t     cop_mem_ben;
    rop_bus_pkg::word_t    cop_mem_wdata;
    rop_bus_pkg::word_t    cop_mem_rdata;
    rop_bus_pkg::addr_t    cop_mem_addr;

    logic [2:0]  stall_cnt;   // Memory model countdown
    logic [2:0]  stall_load;  // Armed while the port is idle
    logic        err_inject;
    logic [15:0] lfsr_state;
    test_row_t   rows[$];

    rop_ba_cop DUT (.*); // Default seed

    // ------------------------------
    // Clock and memory model
    // ------------------------------
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // An injected error keeps stall up, so only the error can end the transfer
    assign cop_mem_stall = cop_mem_cen && ((stall_cnt != 3'd0) || err_inject);
    assign cop_mem_error = cop_mem_cen && err_inject && (stall_cnt == 3'd0);

    always @(posedge clk) begin
        if (!rst_n || !cop_mem_cen) begin
            stall_cnt <= stall_load;        // Reload between transfers
        end else if (stall_cnt != 3'd0) begin
            stall_cnt <= stall_cnt - 3'd1;
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()}; // One step per bit
        end
        return v;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s got %h exp %h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_logic(input logic [6:0] f7, input int op, input logic keep);
        test_row_t  r;
        logic [4:0] rd;
        r       = '0;
        rd      = 5'(rand_bits(5));
        r.rs1   = rand_bits(32);
        r.rs2   = rand_bits(32);
        r.instr = {f7, 5'd2, 5'd1, 3'b001, rd, ISE_OP};
        case (op)
            0:       r.exp_byte = r.rs1[7:0] ^ r.rs2[7:0];
            1:       r.exp_byte = r.rs1[7:0] & r.rs2[7:0];
            default: r.exp_byte = r.rs1[7:0] | r.rs2[7:0];
        endcase
        r.exp_acc     = 1'b1;
        r.exp_wen     = 1'b1;
        r.exp_rd      = keep ? 5'd10 + {2'b00, rd[2:0]} : rd; // a0 based for K
        r.exp_rd_byte = keep ? 3'd4 : {1'b0, rd[4:3]};
        rows.push_back(r);
    endtask

    task automatic add_mem(input logic store, input logic keep, input logic err);
        test_row_t   r;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] addr;
        r       = '0;
        imm     = 12'(rand_bits(12));
        rd      = 5'(rand_bits(5));
        r.rs1   = rand_bits(32);
        r.rs2   = rand_bits(32);
        r.rdata = rand_bits(32);
        r.stall = 3'(rand_bits(3));
        r.err   = err;
        f3      = keep ? 3'b011 : 3'b010;
        addr    = r.rs1 + {{20{imm[11]}}, imm};
        if (store) begin
            r.instr = {imm[11:5], 5'd2, 5'd1, 3'b000, imm[4:0], ISE_OP}; // S form
        end else begin
            r.instr = {imm, 5'd1, f3, rd, ISE_OP};
        end
        r.exp_acc     = 1'b1;
        r.is_mem      = 1'b1;
        r.exp_wen     = !store;
        r.exp_mem_wen = store;
        r.exp_addr    = {addr[31:2], 2'b00};
        r.exp_ben     = 4'b0001 << addr[1:0];
        r.exp_err     = !err ? 2'd0 : (store ? 2'd2 : 2'd1);
        r.exp_rd      = keep ? 5'd10 + {2'b00, rd[2:0]} : rd;
        r.exp_rd_byte = keep ? 3'd4 : {1'b0, rd[4:3]};
        rows.push_back(r);
    endtask

    task automatic add_bad(input logic [31:0] instr);
        test_row_t r;
        r       = '0;
        r.instr = instr;
        r.rs1   = rand_bits(32);
        rows.push_back(r);
    endtask

    // ------------------------------
    // Row driver
    // ------------------------------
    task automatic run_row(input test_row_t r);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        cop_req       = 1'b0;
        stall_load    = r.stall;
        err_inject    = r.err;
        cop_mem_rdata = r.rdata;
        @(negedge clk);
        compare("clk_req/cop_acc/cop_rsp/cop_wen/cop_mem_cen idle",
                32'({clk_req, cop_acc, cop_rsp, cop_wen, cop_mem_cen}), 32'd0);
        @(posedge clk);
        #1;
        cop_req      = 1'b1;
        cop_instr_in = r.instr;
        cop_rs1      = r.rs1;
        cop_rs2      = r.rs2;
        @(negedge clk);
        compare("clk_req", 32'(clk_req), 32'd1);
        compare("cop_acc", 32'(cop_acc), 32'(r.exp_acc));
        if (!r.exp_acc) begin
            compare("cop_rsp", 32'(cop_rsp), 32'd0);
            compare("cop_mem_cen", 32'(cop_mem_cen), 32'd0);
        end else begin
            while (!cop_rsp) begin
                compare("cop_mem_stall", 32'(cop_mem_stall), 32'd1); // Held off by stall only
                compare("cop_mem_error", 32'(cop_mem_error), 32'd0);
                compare("cop_wen", 32'(cop_wen), 32'd0);
                cycles++;
                if (cycles > TIMEOUT) begin
                    $display("No response from the DUT after %0d cycles", TIMEOUT);
                    $display("Simulation FAILED");
                    $fatal(1);
                end
                @(negedge clk);
            end
            compare("stall cycles", 32'(cycles), 32'(r.stall));
            compare("cop_wen", 32'(cop_wen), 32'(r.exp_wen));
            compare("cop_mem_cen", 32'(cop_mem_cen), 32'(r.is_mem));
            compare("cop_mem_ld_error", 32'(cop_mem_ld_error), 32'(r.exp_err == 2'd1));
            compare("cop_mem_st_error", 32'(cop_mem_st_error), 32'(r.exp_err == 2'd2));
            if (r.exp_wen) begin
                compare("cop_rd", 32'(cop_rd), 32'(r.exp_rd));
                compare("cop_rd_byte", 32'(cop_rd_byte), 32'(r.exp_rd_byte));
            end
            if (r.is_mem) begin
                compare("cop_mem_addr", cop_mem_addr, r.exp_addr);
                compare("cop_mem_ben", 32'(cop_mem_ben), 32'(r.exp_ben));
                compare("cop_mem_wen", 32'(cop_mem_wen), 32'(r.exp_mem_wen));
                if (r.exp_mem_wen) begin
                    compare("cop_mem_wdata", cop_mem_wdata, r.rs2);
                end else begin
                    compare("cop_wdata", cop_wdata, r.rdata); // Load data, whole word
                end
            end else begin
                compare("cop_wdata[7:0]", 32'(cop_wdata[7:0]), 32'(r.exp_byte));
            end
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int rep;
        rst_n         = 1'b0;
        cop_req       = 1'b0;
        cop_instr_in  = '0;
        cop_rs1       = '0;
        cop_rs2       = '0;
        cop_mem_rdata = '0;
        stall_load    = 3'd0;
        err_inject    = 1'b0;
        lfsr_state    = 16'd19;

        add_bad({7'b0000000, 5'd2, 5'd1, 3'b001, 5'd3, 7'b0110011}); // Wrong opcode
        add_bad({7'b0000000, 5'd2, 5'd1, 3'b100, 5'd3, ISE_OP});
        add_bad({7'b0000000, 5'd2, 5'd1, 3'b111, 5'd3, ISE_OP});
        add_bad({7'b0000110, 5'd2, 5'd1, 3'b001, 5'd3, ISE_OP});     // Unused f7
        add_bad({7'b1000000, 5'd2, 5'd1, 3'b001, 5'd3, ISE_OP});
        for (rep = 0; rep < 2; rep++) begin
            add_logic(7'b0000000, 0, 1'b0);
            add_logic(7'b0000001, 0, 1'b1);
            add_logic(7'b0000010, 1, 1'b0);
            add_logic(7'b0000011, 1, 1'b1);
            add_logic(7'b0000100, 2, 1'b0);
            add_logic(7'b0000101, 2, 1'b1);
        end
        for (rep = 0; rep < 3; rep++) begin
            add_mem(1'b0, 1'b0, rep == 2);   // LB.B
            add_mem(1'b0, 1'b1, rep == 1);   // LB.BK
            add_mem(1'b1, 1'b0, rep == 2);   // SB.B
        end

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (rows[i]) begin
            run_row(rows[i]);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule
